// File: hdl/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Cache geometry
`define CACHE_WAYS 4
`define CACHE_SETS 16

// Port widths
`define CACHE_ADDR_W 32
`define CACHE_LINE_W 256
`define CACHE_WORD_W 32

`endif

// File: hdl/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]     addr_t;
    typedef logic [`CACHE_WORD_W-1:0]     word_t;
    typedef logic [`CACHE_LINE_W-1:0]     line_t;
    typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;
    typedef logic [`CACHE_WORD_W/8-1:0]   wmask_t;
    typedef logic [`CACHE_LINE_W/8-1:0]   lmask_t;
    typedef logic [`CACHE_WAYS-2:0]       plru_t;

    // Upper address bits left after index and byte offset
    typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_SETS)-$clog2(`CACHE_LINE_W/8)-1:0] tag_t;

    typedef enum logic [2:0] {
        idle_s,
        compare_tag_s,
        writeback_s,
        allocate_s,
        refill_s
    } cache_state_t;

    typedef struct packed {
        addr_t  addr;
        logic   rmask;
        wmask_t wmask;
        word_t  wdata;
    } ufp_req_t;

    typedef struct packed {
        addr_t addr;
        logic  read;
        logic  write;
        line_t wdata;
    } dfp_req_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

// File: hdl/cache_tag_store.sv
`include "cache_config.svh"

module cache_tag_store (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cache_pkg::index_t      index,
    input  logic [`CACHE_WAYS-1:0] we,
    input  cache_pkg::tag_entry_t  wentry,
    output cache_pkg::tag_entry_t  rentry [`CACHE_WAYS]
);

    generate
        for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
            logic [`CACHE_SETS-1:0] valid_q;
            logic [`CACHE_SETS-1:0] dirty_q;
            cache_pkg::tag_t        tag_mem [`CACHE_SETS];
            logic                   rvalid;
            logic                   rdirty;
            cache_pkg::tag_t        rtag;

            // Valid and dirty bits per set
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    valid_q <= '0;
                    dirty_q <= '0;
                end else if (we[w]) begin
                    valid_q[index] <= wentry.valid;
                    dirty_q[index] <= wentry.dirty;
                end
            end

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    rvalid <= 1'b0;
                    rdirty <= 1'b0;
                end else begin
                    rvalid <= valid_q[index];
                    rdirty <= dirty_q[index];
                end
            end

            always_ff @(posedge clk) begin
                if (we[w]) begin
                    tag_mem[index] <= wentry.tag;
                end
                rtag <= tag_mem[index];
            end

            assign rentry[w].valid = rvalid;
            assign rentry[w].dirty = rdirty;
            assign rentry[w].tag   = rtag;
        end
    endgenerate

    // Control only ever fills or updates a single way
    a_tag_we_onehot: assert property (
        @(posedge clk) disable iff (!arst_n) $onehot0(we)
    );

endmodule

// File: hdl/cache_data_store.sv
`include "cache_config.svh"

module cache_data_store (
    input  logic                   clk,
    input  cache_pkg::index_t      index,
    input  logic [`CACHE_WAYS-1:0] we,
    input  cache_pkg::lmask_t      lmask,
    input  cache_pkg::line_t       wline,
    output cache_pkg::line_t       rline [`CACHE_WAYS]
);

    localparam int LINE_BYTES = `CACHE_LINE_W / 8;

    generate
        for (genvar w = 0; w < `CACHE_WAYS; w++) begin : g_way
            cache_pkg::line_t line_mem [`CACHE_SETS];

            always_ff @(posedge clk) begin
                if (we[w]) begin
                    // Byte enables from lmask
                    for (int b = 0; b < LINE_BYTES; b++) begin
                        if (lmask[b]) begin
                            line_mem[index][8*b +: 8] <= wline[8*b +: 8];
                        end
                    end
                end
                rline[w] <= line_mem[index];
            end
        end
    endgenerate

    a_data_we_onehot: assert property (
        @(posedge clk) $onehot0(we)
    );

endmodule

// File: hdl/cache_control.sv
`include "cache_config.svh"

module cache_control (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cache_pkg::ufp_req_t    ufp_req,
    output cache_pkg::word_t       ufp_rdata,
    output logic                   ufp_resp,
    output cache_pkg::dfp_req_t    dfp_req,
    input  cache_pkg::line_t       dfp_rdata,
    input  logic                   dfp_resp,
    output cache_pkg::index_t      index,
    output logic [`CACHE_WAYS-1:0] tag_we,
    output cache_pkg::tag_entry_t  wentry,
    input  cache_pkg::tag_entry_t  rentry [`CACHE_WAYS],
    output logic [`CACHE_WAYS-1:0] data_we,
    output cache_pkg::lmask_t      lmask,
    output cache_pkg::line_t       wline,
    input  cache_pkg::line_t       rline [`CACHE_WAYS]
);

    localparam int OFF_W  = $clog2(`CACHE_LINE_W / 8);
    localparam int IDX_W  = $bits(cache_pkg::index_t);
    localparam int TAG_W  = $bits(cache_pkg::tag_t);
    localparam int WPL    = `CACHE_LINE_W / `CACHE_WORD_W;
    localparam int WORD_B = `CACHE_WORD_W / 8;

    cache_pkg::cache_state_t state, state_next;
    cache_pkg::plru_t [`CACHE_SETS-1:0] plru_q;
    cache_pkg::plru_t        plru_cur;
    cache_pkg::plru_t        plru_upd;
    cache_pkg::tag_t         req_tag;
    logic [$clog2(WPL)-1:0]  word_sel;
    logic                    req_valid;
    logic [`CACHE_WAYS-1:0]  hit_vec;
    logic                    hit;
    cache_pkg::way_t         hit_way;
    cache_pkg::way_t         victim;
    cache_pkg::way_t         victim_q;

    assign index     = ufp_req.addr[OFF_W +: IDX_W];
    assign req_tag   = ufp_req.addr[`CACHE_ADDR_W-1 -: TAG_W];
    assign word_sel  = ufp_req.addr[OFF_W-1 -: $clog2(WPL)];
    assign req_valid = ufp_req.rmask || (|ufp_req.wmask);
    assign plru_cur  = plru_q[index];

    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_vec[w] = rentry[w].valid && (rentry[w].tag == req_tag);
            if (hit_vec[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;

    // Invalid ways first, lowest wins, else walk the tree
    always_comb begin
        if (!plru_cur[0]) begin
            victim = plru_cur[1] ? 2'd1 : 2'd0;
        end else begin
            victim = plru_cur[2] ? 2'd3 : 2'd2;
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (!rentry[w].valid) begin
                victim = cache_pkg::way_t'(w);
            end
        end
    end

    // Point the path bits away from the way just used
    always_comb begin
        plru_upd = plru_cur;
        case (hit_way)
            2'd0: begin
                plru_upd[0] = 1'b1;
                plru_upd[1] = 1'b1;
            end
            2'd1: begin
                plru_upd[0] = 1'b1;
                plru_upd[1] = 1'b0;
            end
            2'd2: begin
                plru_upd[0] = 1'b0;
                plru_upd[2] = 1'b1;
            end
            default: begin
                plru_upd[0] = 1'b0;
                plru_upd[2] = 1'b0;
            end
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_pkg::idle_s: begin
                if (req_valid) begin
                    state_next = cache_pkg::compare_tag_s;
                end
            end
            cache_pkg::compare_tag_s: begin
                if (hit) begin
                    state_next = cache_pkg::idle_s;
                end else if (rentry[victim].valid && rentry[victim].dirty) begin
                    state_next = cache_pkg::writeback_s;
                end else begin
                    state_next = cache_pkg::allocate_s;
                end
            end
            cache_pkg::writeback_s: begin
                if (dfp_resp) begin
                    state_next = cache_pkg::allocate_s;
                end
            end
            cache_pkg::allocate_s: begin
                if (dfp_resp) begin
                    state_next = cache_pkg::refill_s;
                end
            end
            default: begin
                state_next = cache_pkg::compare_tag_s;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= cache_pkg::idle_s;
            plru_q <= '0;
        end else begin
            state <= state_next;
            if (ufp_resp) begin
                plru_q[index] <= plru_upd;
            end
        end
    end

    // Victim is fixed for the whole miss
    always_ff @(posedge clk) begin
        if (state == cache_pkg::compare_tag_s && !hit) begin
            victim_q <= victim;
        end
    end

    assign ufp_resp  = (state == cache_pkg::compare_tag_s) && hit;
    assign ufp_rdata = rline[hit_way][word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

    always_comb begin
        dfp_req.read  = (state == cache_pkg::allocate_s);
        dfp_req.write = (state == cache_pkg::writeback_s);
        dfp_req.wdata = rline[victim_q];
        if (state == cache_pkg::writeback_s) begin
            dfp_req.addr = {rentry[victim_q].tag, index, {OFF_W{1'b0}}};
        end else begin
            dfp_req.addr = {ufp_req.addr[`CACHE_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        end
    end

    always_comb begin
        tag_we       = '0;
        data_we      = '0;
        wentry.valid = 1'b1;
        wentry.dirty = 1'b1;
        wentry.tag   = req_tag;
        wline        = {WPL{ufp_req.wdata}};
        lmask        = cache_pkg::lmask_t'(ufp_req.wmask) << (word_sel * WORD_B);
        if (state == cache_pkg::compare_tag_s && hit && (|ufp_req.wmask)) begin
            tag_we[hit_way]  = 1'b1;
            data_we[hit_way] = 1'b1;
        end else if (state == cache_pkg::allocate_s && dfp_resp) begin
            // Fill the whole line, clean
            tag_we[victim_q]  = 1'b1;
            data_we[victim_q] = 1'b1;
            wentry.dirty      = 1'b0;
            wline             = dfp_rdata;
            lmask             = '1;
        end
    end

    // A freshly filled line hits on the compare that follows
    a_refill_hits: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == cache_pkg::refill_s) |=> ufp_resp
    );

    a_dfp_req_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        (dfp_req.read || dfp_req.write) && !dfp_resp |=> $stable(dfp_req)
    );

    // Tag store must never hold the same tag twice in a set
    a_single_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        (state == cache_pkg::compare_tag_s) |-> $onehot0(hit_vec)
    );

endmodule

// File: hdl/cache.sv
`include "cache_config.svh"

module cache (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::ufp_req_t ufp_req,
    output cache_pkg::word_t    ufp_rdata,
    output logic                ufp_resp,
    output cache_pkg::dfp_req_t dfp_req,
    input  cache_pkg::line_t    dfp_rdata,
    input  logic                dfp_resp
);

    cache_pkg::index_t      index;
    logic [`CACHE_WAYS-1:0] tag_we;
    logic [`CACHE_WAYS-1:0] data_we;
    cache_pkg::tag_entry_t  wentry;
    cache_pkg::tag_entry_t  rentry [`CACHE_WAYS];
    cache_pkg::lmask_t      lmask;
    cache_pkg::line_t       wline;
    cache_pkg::line_t       rline [`CACHE_WAYS];

    cache_tag_store u_tag_store (
        .clk    (clk),
        .arst_n (arst_n),
        .index  (index),
        .we     (tag_we),
        .wentry (wentry),
        .rentry (rentry)
    );

    cache_data_store u_data_store (
        .clk   (clk),
        .index (index),
        .we    (data_we),
        .lmask (lmask),
        .wline (wline),
        .rline (rline)
    );

    cache_control u_control (
        .clk       (clk),
        .arst_n    (arst_n),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp),
        .index     (index),
        .tag_we    (tag_we),
        .wentry    (wentry),
        .rentry    (rentry),
        .data_we   (data_we),
        .lmask     (lmask),
        .wline     (wline),
        .rline     (rline)
    );

endmodule

// File: dv/cache_mem_model.sv
module cache_mem_model (
    input  logic                clk,
    input  cache_pkg::dfp_req_t dfp_req,
    output cache_pkg::line_t    dfp_rdata,
    output logic                dfp_resp
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_DELAY = 5;

    // Lines written back so far, keyed by line address
    cache_pkg::line_t lines [cache_pkg::addr_t];

    function automatic logic [7:0] initial_byte(cache_pkg::addr_t a);
        logic [31:0] h;
        h = (a ^ 32'h2c1b_3c6d) * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic cache_pkg::line_t fetch_line(cache_pkg::addr_t line_addr);
        cache_pkg::line_t l;
        if (lines.exists(line_addr)) begin
            l = lines[line_addr];
        end else begin
            for (int b = 0; b < 32; b++) begin
                l[8*b +: 8] = initial_byte(line_addr + b);
            end
        end
        return l;
    endfunction

    task automatic serve_request();
        int delay;
        delay = $urandom_range(MAX_DELAY, 0);
        @(posedge clk);
        #1;
        for (int i = 0; i < delay; i++) begin
            @(posedge clk);
            #1;
        end
        if (dfp_req.write) begin
            lines[dfp_req.addr] = dfp_req.wdata;
        end else begin
            dfp_rdata = fetch_line(dfp_req.addr);
        end
        dfp_resp = 1'b1;
        @(posedge clk);
        #1;
        dfp_resp = 1'b0;
    endtask

    initial begin
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (dfp_req.read || dfp_req.write) begin
                serve_request();
            end
        end
    end

endmodule

// File: dv/cache_tb.sv
`include "cache_config.svh"

module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ACCESSES = 2000;
    localparam int TIMEOUT      = 200;

    logic                clk;
    logic                arst_n;
    cache_pkg::ufp_req_t ufp_req;
    cache_pkg::word_t    ufp_rdata;
    logic                ufp_resp;
    cache_pkg::dfp_req_t dfp_req;
    cache_pkg::line_t    dfp_rdata;
    logic                dfp_resp;

    // CPU view of the bytes written so far
    logic [7:0]        mem_bytes [cache_pkg::addr_t];
    logic              shadow_valid [`CACHE_SETS][`CACHE_WAYS];
    logic              shadow_dirty [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::tag_t   shadow_tag   [`CACHE_SETS][`CACHE_WAYS];
    cache_pkg::plru_t  shadow_plru  [`CACHE_SETS];
    cache_pkg::tag_t   tag_pool [4][6];
    cache_pkg::index_t set_pool [4];

    // Memory transactions seen during one access
    logic              txn_read  [$];
    logic              txn_write [$];
    cache_pkg::addr_t  txn_addr  [$];
    cache_pkg::line_t  txn_line  [$];

    cache dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .ufp_req   (ufp_req),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    cache_mem_model mem (
        .clk       (clk),
        .dfp_req   (dfp_req),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_word(string name, cache_pkg::word_t exp, cache_pkg::word_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_line(string name, cache_pkg::line_t exp, cache_pkg::line_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(string name, cache_pkg::addr_t exp, cache_pkg::addr_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch %s: expected %h actual %h", name, exp, act));
        end
    endtask

    function automatic logic [7:0] initial_byte(cache_pkg::addr_t a);
        logic [31:0] h;
        h = (a ^ 32'h2c1b_3c6d) * 32'h9e37_79b1;
        return h[31:24] ^ h[7:0];
    endfunction

    function automatic logic [7:0] model_byte(cache_pkg::addr_t a);
        if (mem_bytes.exists(a)) begin
            return mem_bytes[a];
        end else begin
            return initial_byte(a);
        end
    endfunction

    function automatic cache_pkg::word_t model_word(cache_pkg::addr_t a);
        cache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = model_byte(a + b);
        end
        return w;
    endfunction

    function automatic cache_pkg::line_t model_line(cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int b = 0; b < 32; b++) begin
            l[8*b +: 8] = model_byte(a + b);
        end
        return l;
    endfunction

    // Lowest invalid way, else follow the tree
    function automatic cache_pkg::way_t pick_victim(cache_pkg::index_t s);
        cache_pkg::plru_t p;
        cache_pkg::way_t  v;
        logic             found;
        p     = shadow_plru[s];
        v     = {p[0], p[0] ? p[2] : p[1]};
        found = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!found && !shadow_valid[s][w]) begin
                v     = cache_pkg::way_t'(w);
                found = 1'b1;
            end
        end
        return v;
    endfunction

    function automatic void touch_way(cache_pkg::index_t s, cache_pkg::way_t w);
        if (!w[1]) begin
            shadow_plru[s][0] = 1'b1;
            shadow_plru[s][1] = ~w[0];
        end else begin
            shadow_plru[s][0] = 1'b0;
            shadow_plru[s][2] = ~w[0];
        end
    endfunction

    task automatic run_access(int n);
        cache_pkg::ufp_req_t req;
        cache_pkg::index_t   set;
        cache_pkg::tag_t     tag;
        cache_pkg::way_t     way;
        cache_pkg::addr_t    line_addr;
        cache_pkg::addr_t    victim_addr;
        cache_pkg::line_t    victim_line;
        cache_pkg::word_t    rdata;
        logic                hit;
        logic                write_back;
        logic                dfp_seen;
        int                  pick;
        int                  cycles;
        int                  exp_n;

        pick      = $urandom_range(3, 0);
        set       = set_pool[pick];
        tag       = tag_pool[pick][$urandom_range(5, 0)];
        req.addr  = {tag, set, 3'($urandom_range(7, 0)), 2'b00};
        line_addr = {req.addr[31:5], 5'b0};
        req.wdata = $urandom();
        if ($urandom_range(1, 0) == 0) begin
            req.rmask = 1'b1;
            req.wmask = '0;
        end else begin
            req.rmask = 1'b0;
            req.wmask = 4'($urandom_range(15, 1));
        end

        hit = 1'b0;
        way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (shadow_valid[set][w] && shadow_tag[set][w] == tag) begin
                hit = 1'b1;
                way = cache_pkg::way_t'(w);
            end
        end
        write_back  = 1'b0;
        victim_addr = '0;
        victim_line = '0;
        if (!hit) begin
            way         = pick_victim(set);
            write_back  = shadow_valid[set][way] && shadow_dirty[set][way];
            victim_addr = {shadow_tag[set][way], set, 5'b0};
            victim_line = model_line(victim_addr);
        end

        ufp_req = req;
        txn_read.delete();
        txn_write.delete();
        txn_addr.delete();
        txn_line.delete();
        dfp_seen = 1'b0;
        cycles   = 0;
        @(negedge clk);
        while (!ufp_resp) begin
            if (dfp_req.read || dfp_req.write) begin
                dfp_seen = 1'b1;
            end
            if (dfp_resp) begin
                txn_read.push_back(dfp_req.read);
                txn_write.push_back(dfp_req.write);
                txn_addr.push_back(dfp_req.addr);
                txn_line.push_back(dfp_req.wdata);
            end
            cycles++;
            if (cycles > TIMEOUT) begin
                abort_run($sformatf("access %0d got no response within %0d cycles", n, TIMEOUT));
            end
            @(negedge clk);
        end
        if (dfp_req.read || dfp_req.write) begin
            dfp_seen = 1'b1;
        end
        rdata = ufp_rdata;

        if (hit) begin
            if (dfp_seen) begin
                abort_run($sformatf("access %0d hit but caused memory traffic", n));
            end
            if (cycles != 1) begin
                abort_run($sformatf("access %0d hit took %0d cycles instead of 1", n, cycles));
            end
        end else begin
            exp_n = write_back ? 2 : 1;
            if (txn_write.size() != exp_n) begin
                abort_run($sformatf("access %0d expected %0d memory transactions, saw %0d",
                                    n, exp_n, txn_write.size()));
            end
            if (write_back) begin
                if (!txn_write[0] || txn_read[0]) begin
                    abort_run($sformatf("access %0d did not write back first", n));
                end
                check_addr($sformatf("writeback_addr access %0d", n), victim_addr, txn_addr[0]);
                check_line($sformatf("writeback_line access %0d", n), victim_line, txn_line[0]);
            end
            if (txn_write[exp_n-1] || !txn_read[exp_n-1]) begin
                abort_run($sformatf("access %0d issued no plain fetch where one was due", n));
            end
            check_addr($sformatf("fetch_addr access %0d", n), line_addr, txn_addr[exp_n-1]);
            shadow_valid[set][way] = 1'b1;
            shadow_dirty[set][way] = 1'b0;
            shadow_tag[set][way]   = tag;
        end

        touch_way(set, way);
        if (|req.wmask) begin
            shadow_dirty[set][way] = 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (req.wmask[b]) begin
                    mem_bytes[req.addr + b] = req.wdata[8*b +: 8];
                end
            end
        end else begin
            check_word($sformatf("read_data access %0d", n), model_word(req.addr), rdata);
        end

        @(posedge clk);
        #1;
        ufp_req = '0;
    endtask

    initial begin
        void'($urandom(73));
        ufp_req = '0;
        arst_n  = 1'b0;
        set_pool[0] = 4'd2;
        set_pool[1] = 4'd7;
        set_pool[2] = 4'd9;
        set_pool[3] = 4'd14;
        // Low tag bits keep the six tags of a set distinct
        for (int s = 0; s < 4; s++) begin
            for (int k = 0; k < 6; k++) begin
                tag_pool[s][k] = {20'($urandom()), 3'(k)};
            end
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            shadow_plru[s] = '0;
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                shadow_valid[s][w] = 1'b0;
                shadow_dirty[s][w] = 1'b0;
                shadow_tag[s][w]   = '0;
            end
        end

        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(posedge clk);
        #1;

        for (int n = 0; n < NUM_ACCESSES; n++) begin
            run_access(n);
            repeat ($urandom_range(2, 0)) begin
                @(posedge clk);
                #1;
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/cache_control.sv
hdl/cache.sv
dv/cache_mem_model.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cache_tb -f files.f -o cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/cache_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation binary exited with status $status"
    exit $status
fi

exit 0
